// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wb_sel_e;

	// Data port command
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_READ  = 2'd1,
		MEM_WRITE = 2'd2
	} mem_cmd_e;

	//**********************************************************************
	// Pipeline registers
	//**********************************************************************

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] inst;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] rs2_data;
		logic [31:0] imm;
		alu_op_e     alu_op;
		logic        branch;
		logic        bne;
		logic        jump;
		mem_cmd_e    mem_cmd;
		logic        reg_wen;
		logic [4:0]  rd;
		wb_sel_e     wb_sel;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] alu_result;
		logic [31:0] rs2_data;
		logic [31:0] pc4;
		mem_cmd_e    mem_cmd;
		logic        reg_wen;
		logic [4:0]  rd;
		wb_sel_e     wb_sel;
	} ex_mem_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] alu_result;
		logic [31:0] load_data;
		logic [31:0] pc4;
		logic        reg_wen;
		logic [4:0]  rd;
		wb_sel_e     wb_sel;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               stall,
	input  wire               flush,
	input  wire [31:0]        redirect_pc,
	output logic              inst_start,
	input  wire               inst_ready,
	output logic [31:0]       i_addr,
	input  wire [31:0]        inst,
	input  wire               inst_valid,
	output core_pkg::if_id_t  if_id
);

	logic        running;
	logic [31:0] pc;
	logic        pending;
	logic        drop;
	logic        buf_valid;
	logic [31:0] buf_pc;
	logic [31:0] buf_inst;
	logic        accept;

	// Response to a request made before a flush is thrown away
	assign accept = inst_valid && pending && !drop;

	assign inst_start = running && inst_ready && !pending && !buf_valid && !stall && !flush;
	assign i_addr = pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running     <= 1'b0;
			pc          <= RESET_PC;
			pending     <= 1'b0;
			drop        <= 1'b0;
			buf_valid   <= 1'b0;
			if_id.valid <= 1'b0;
		end else begin
			running <= 1'b1;
			if (inst_start)
				pending <= 1'b1;
			if (inst_valid) begin
				pending <= 1'b0;
				drop    <= 1'b0;
			end
			if (flush) begin
				pc          <= redirect_pc;
				buf_valid   <= 1'b0;
				if_id.valid <= 1'b0;
				drop        <= pending && !inst_valid;
			end else begin
				if (accept)
					pc <= pc + 32'd4;
				if (!stall) begin
					if (buf_valid) begin
						if_id     <= '{valid: 1'b1, pc: buf_pc, inst: buf_inst};
						buf_valid <= 1'b0;
					end else if (accept) begin
						if_id <= '{valid: 1'b1, pc: pc, inst: inst};
					end else begin
						if_id.valid <= 1'b0;
					end
				end else if (accept) begin
					// Park the word until the pipeline moves again
					buf_valid <= 1'b1;
					buf_pc    <= pc;
					buf_inst  <= inst;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               stall,
	input  wire               flush,
	input  core_pkg::if_id_t  if_id,
	output logic [4:0]        rs1_addr,
	output logic [4:0]        rs2_addr,
	input  wire [31:0]        rs1_data,
	input  wire [31:0]        rs2_data,
	output core_pkg::id_ex_t  id_ex
);

	logic [31:0]      ir;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic [31:0]      imm_i;
	logic [31:0]      imm_s;
	logic [31:0]      imm_b;
	logic [31:0]      imm_u;
	logic [31:0]      imm_j;
	core_pkg::id_ex_t d;

	assign ir       = if_id.inst;
	assign funct3   = ir[14:12];
	assign funct7   = ir[31:25];
	assign rs1_addr = ir[19:15];
	assign rs2_addr = ir[24:20];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'b0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	// Defaults describe a no-operation
	always_comb begin
		d          = '0;
		d.valid    = if_id.valid;
		d.pc       = if_id.pc;
		d.op1      = rs1_data;
		d.op2      = rs2_data;
		d.rs2_data = rs2_data;
		d.alu_op   = core_pkg::ALU_ADD;
		d.mem_cmd  = core_pkg::MEM_NONE;
		d.wb_sel   = core_pkg::WB_ALU;
		d.rd       = ir[11:7];
		case (ir[6:0])
			core_pkg::OPC_OP: begin
				if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
					d.reg_wen = 1'b1;
					case (funct3)
						3'b000: d.alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
						3'b010: d.alu_op = core_pkg::ALU_SLT;
						3'b100: d.alu_op = core_pkg::ALU_XOR;
						3'b110: d.alu_op = core_pkg::ALU_OR;
						3'b111: d.alu_op = core_pkg::ALU_AND;
						default: d.reg_wen = 1'b0;
					endcase
				end
			end
			core_pkg::OPC_OP_IMM: begin
				d.imm     = imm_i;
				d.op2     = imm_i;
				d.reg_wen = funct3 == 3'b000;
			end
			core_pkg::OPC_LUI: begin
				d.imm     = imm_u;
				d.op2     = imm_u;
				d.alu_op  = core_pkg::ALU_PASS_B;
				d.reg_wen = 1'b1;
			end
			core_pkg::OPC_LOAD: begin
				if (funct3 == 3'b010) begin
					d.imm     = imm_i;
					d.op2     = imm_i;
					d.mem_cmd = core_pkg::MEM_READ;
					d.wb_sel  = core_pkg::WB_MEM;
					d.reg_wen = 1'b1;
				end
			end
			core_pkg::OPC_STORE: begin
				if (funct3 == 3'b010) begin
					d.imm     = imm_s;
					d.op2     = imm_s;
					d.mem_cmd = core_pkg::MEM_WRITE;
				end
			end
			core_pkg::OPC_BRANCH: begin
				d.imm    = imm_b;
				d.branch = funct3 == 3'b000 || funct3 == 3'b001;
				d.bne    = funct3 == 3'b001;
			end
			core_pkg::OPC_JAL: begin
				d.imm     = imm_j;
				d.jump    = 1'b1;
				d.wb_sel  = core_pkg::WB_PC4;
				d.reg_wen = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush)
			id_ex.valid <= 1'b0;
		else if (!stall)
			id_ex <= d;
	end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                stall,
	input  core_pkg::id_ex_t   id_ex,
	output logic               flush,
	output logic [31:0]        redirect_pc,
	output core_pkg::ex_mem_t  ex_mem
);

	logic [31:0] alu_result;
	logic [31:0] pc4;
	logic        equal;
	logic        taken;

	//**********************************************************************
	// ALU
	//**********************************************************************

	always_comb begin
		case (id_ex.alu_op)
			core_pkg::ALU_ADD:    alu_result = id_ex.op1 + id_ex.op2;
			core_pkg::ALU_SUB:    alu_result = id_ex.op1 - id_ex.op2;
			core_pkg::ALU_AND:    alu_result = id_ex.op1 & id_ex.op2;
			core_pkg::ALU_OR:     alu_result = id_ex.op1 | id_ex.op2;
			core_pkg::ALU_XOR:    alu_result = id_ex.op1 ^ id_ex.op2;
			core_pkg::ALU_SLT:    alu_result = {31'b0, $signed(id_ex.op1) < $signed(id_ex.op2)};
			core_pkg::ALU_PASS_B: alu_result = id_ex.op2;
			default:              alu_result = 32'b0;
		endcase
	end

	//**********************************************************************
	// Branch and jump
	//**********************************************************************

	assign pc4   = id_ex.pc + 32'd4;
	assign equal = id_ex.op1 == id_ex.op2;
	assign taken = id_ex.valid && (id_ex.jump || (id_ex.branch && (equal != id_ex.bne)));

	// Fires once, in the cycle the branch leaves execute
	assign flush       = taken && !stall;
	assign redirect_pc = id_ex.pc + id_ex.imm;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.valid <= 1'b0;
		end else if (!stall) begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.alu_result <= alu_result;
			ex_mem.rs2_data   <= id_ex.rs2_data;
			ex_mem.pc4        <= pc4;
			ex_mem.mem_cmd    <= id_ex.mem_cmd;
			ex_mem.reg_wen    <= id_ex.reg_wen;
			ex_mem.rd         <= id_ex.rd;
			ex_mem.wb_sel     <= id_ex.wb_sel;
		end
	end

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  wire                 clk,
	input  wire                 rst_n,
	input  core_pkg::ex_mem_t   ex_mem,
	output logic                stall,
	output core_pkg::mem_cmd_e  d_cmd,
	input  wire                 d_cmd_ready,
	output logic [31:0]         d_addr,
	output logic [31:0]         wdata,
	output logic [31:0]         wmask,
	input  wire [31:0]          rdata,
	input  wire                 rdata_valid,
	output core_pkg::mem_wb_t   mem_wb
);

	typedef enum logic [1:0] {IDLE, CMD, WAIT_DATA} state_e;

	state_e state;
	logic   mem_op;
	logic   presenting;
	logic   done;

	assign mem_op     = ex_mem.valid && ex_mem.mem_cmd != core_pkg::MEM_NONE;
	assign presenting = mem_op && state != WAIT_DATA;

	assign d_cmd  = presenting ? ex_mem.mem_cmd : core_pkg::MEM_NONE;
	assign d_addr = ex_mem.alu_result;
	assign wdata  = ex_mem.rs2_data;
	assign wmask  = ex_mem.mem_cmd == core_pkg::MEM_WRITE ? 32'hffff_ffff : 32'h0;

	// Store ends on accept, load ends on returned data
	assign done  = state == WAIT_DATA ? rdata_valid
		: d_cmd_ready && ex_mem.mem_cmd == core_pkg::MEM_WRITE;
	assign stall = mem_op && !done;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE, CMD: begin
					if (!presenting)
						state <= IDLE;
					else if (!d_cmd_ready)
						state <= CMD;
					else if (ex_mem.mem_cmd == core_pkg::MEM_READ)
						state <= WAIT_DATA;
					else
						state <= IDLE;
				end
				WAIT_DATA: if (rdata_valid) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.valid <= 1'b0;
		end else begin
			mem_wb.valid      <= ex_mem.valid && !stall;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.load_data  <= rdata;
			mem_wb.pc4        <= ex_mem.pc4;
			mem_wb.reg_wen    <= ex_mem.reg_wen;
			mem_wb.rd         <= ex_mem.rd;
			mem_wb.wb_sel     <= ex_mem.wb_sel;
		end
	end

endmodule

`default_nettype wire

// File: verilog/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
	input  wire               clk,
	input  wire               rst_n,
	input  core_pkg::mem_wb_t mem_wb,
	input  wire [4:0]         rs1_addr,
	input  wire [4:0]         rs2_addr,
	output logic [31:0]       rs1_data,
	output logic [31:0]       rs2_data
);

	logic [31:0] regs [32];
	logic [31:0] wb_data;
	logic        wb_en;

	always_comb begin
		case (mem_wb.wb_sel)
			core_pkg::WB_MEM: wb_data = mem_wb.load_data;
			core_pkg::WB_PC4: wb_data = mem_wb.pc4;
			default:          wb_data = mem_wb.alu_result;
		endcase
	end

	// x0 is never written
	assign wb_en = mem_wb.valid && mem_wb.reg_wen && mem_wb.rd != 5'd0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'b0;
		end else if (wb_en) begin
			regs[mem_wb.rd] <= wb_data;
		end
	end

	//**********************************************************************
	// Read ports with write pass-through
	//**********************************************************************

	always_comb begin
		if (rs1_addr == 5'd0)
			rs1_data = 32'b0;
		else if (wb_en && mem_wb.rd == rs1_addr)
			rs1_data = wb_data;
		else
			rs1_data = regs[rs1_addr];
	end

	always_comb begin
		if (rs2_addr == 5'd0)
			rs2_data = 32'b0;
		else if (wb_en && mem_wb.rd == rs2_addr)
			rs2_data = wb_data;
		else
			rs2_data = regs[rs2_addr];
	end

endmodule

`default_nettype wire

// File: verilog/core.sv
`timescale 1ns/1ps
`default_nettype none

module core #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  wire                 clk,
	input  wire                 rst_n,
	output logic                inst_start,
	input  wire                 inst_ready,
	output logic [31:0]         i_addr,
	input  wire [31:0]          inst,
	input  wire                 inst_valid,
	output core_pkg::mem_cmd_e  d_cmd,
	input  wire                 d_cmd_ready,
	output logic [31:0]         d_addr,
	output logic [31:0]         wdata,
	output logic [31:0]         wmask,
	input  wire [31:0]          rdata,
	input  wire                 rdata_valid
);

	logic              stall;
	logic              flush;
	logic [31:0]       redirect_pc;
	logic [4:0]        rs1_addr;
	logic [4:0]        rs2_addr;
	logic [31:0]       rs1_data;
	logic [31:0]       rs2_data;
	core_pkg::if_id_t  if_id;
	core_pkg::id_ex_t  id_ex;
	core_pkg::ex_mem_t ex_mem;
	core_pkg::mem_wb_t mem_wb;

	fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .redirect_pc(redirect_pc),
		.inst_start(inst_start), .inst_ready(inst_ready), .i_addr(i_addr),
		.inst(inst), .inst_valid(inst_valid), .if_id(if_id)
	);

	decode_stage i_decode (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .if_id(if_id),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .id_ex(id_ex)
	);

	execute_stage i_execute (
		.clk(clk), .rst_n(rst_n), .stall(stall), .id_ex(id_ex),
		.flush(flush), .redirect_pc(redirect_pc), .ex_mem(ex_mem)
	);

	memory_stage i_memory (
		.clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .stall(stall),
		.d_cmd(d_cmd), .d_addr(d_addr), .wdata(wdata), .wmask(wmask),
		.d_cmd_ready(d_cmd_ready), .rdata(rdata), .rdata_valid(rdata_valid),
		.mem_wb(mem_wb)
	);

	writeback_stage i_writeback (
		.clk(clk), .rst_n(rst_n), .mem_wb(mem_wb),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

endmodule

`default_nettype wire

// File: test/core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module core_chk (
	input wire                clk,
	input wire                rst_n,
	input wire                inst_start,
	input wire                inst_valid,
	input core_pkg::mem_cmd_e d_cmd,
	input wire                d_cmd_ready,
	input wire [31:0]         d_addr
);

	logic outstanding;

	// Instruction request in flight
	always_ff @(posedge clk) begin
		if (!rst_n)
			outstanding <= 1'b0;
		else if (inst_start)
			outstanding <= 1'b1;
		else if (inst_valid)
			outstanding <= 1'b0;
	end

	a_reset_quiet: assert property (@(posedge clk)
		$rose(rst_n) |-> (!inst_start && d_cmd == core_pkg::MEM_NONE))
		else $error("port active in the first cycle after reset");

	a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(d_cmd != core_pkg::MEM_NONE && !d_cmd_ready)
		|=> (d_cmd == $past(d_cmd) && d_addr == $past(d_addr)))
		else $error("data command changed before it was accepted");

	a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
		inst_start |-> !outstanding)
		else $error("instruction request issued while one is outstanding");

endmodule

bind core core_chk i_core_chk (.*);

`default_nettype wire

// File: test/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam logic [31:0] RESET_PC = 32'h40;
	localparam logic [31:0] NOP = 32'h0000_0013;

	logic               clk;
	logic               rst_n;
	logic               inst_start;
	logic               inst_ready;
	logic [31:0]        i_addr;
	logic [31:0]        inst;
	logic               inst_valid;
	core_pkg::mem_cmd_e d_cmd;
	logic               d_cmd_ready;
	logic [31:0]        d_addr;
	logic [31:0]        wdata;
	logic [31:0]        wmask;
	logic [31:0]        rdata;
	logic               rdata_valid;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	int          prog_n;
	logic        ireq_pend;
	logic [31:0] ireq_addr;
	int          ireq_wait;
	logic        rreq_pend;
	logic [31:0] rreq_addr;
	int          rreq_wait;
	logic        saw_start;
	logic [31:0] first_iaddr;
	logic        saw_cmd;
	logic [1:0]  first_cmd;
	logic [31:0] first_addr;
	logic        finished;
	logic [31:0] st_addr [$];
	logic [31:0] st_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];

	core #(.RESET_PC(RESET_PC)) i_core (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	//**********************************************************************
	// Memory models
	//**********************************************************************

	// Handshakes are taken as the DUT sees them at the rising edge
	always @(posedge clk) begin
		if (!rst_n) begin
			saw_start = 1'b0;
			saw_cmd   = 1'b0;
		end else begin
			if (inst_start) begin
				if (!saw_start)
					first_iaddr = i_addr;
				saw_start = 1'b1;
				ireq_pend = 1'b1;
				ireq_addr = i_addr;
				ireq_wait = $urandom % 4;
			end
			if (d_cmd != core_pkg::MEM_NONE && d_cmd_ready) begin
				if (!saw_cmd) begin
					first_cmd  = d_cmd;
					first_addr = d_addr;
				end
				saw_cmd = 1'b1;
				if (d_cmd == core_pkg::MEM_WRITE) begin
					dmem[d_addr[9:2]] = wdata & wmask;
					st_addr.push_back(d_addr);
					st_data.push_back(wdata & wmask);
					if (d_addr == 32'h100)
						finished = 1'b1;
				end else begin
					rreq_pend = 1'b1;
					rreq_addr = d_addr;
					rreq_wait = $urandom % 4;
				end
			end
		end
	end

	always @(negedge clk) begin
		inst_valid  = 1'b0;
		rdata_valid = 1'b0;
		if (!rst_n) begin
			ireq_pend   = 1'b0;
			rreq_pend   = 1'b0;
			d_cmd_ready = 1'b0;
		end else begin
			if (ireq_pend) begin
				if (ireq_wait == 0) begin
					inst       = imem[ireq_addr[9:2]];
					inst_valid = 1'b1;
					ireq_pend  = 1'b0;
				end else
					ireq_wait--;
			end
			if (rreq_pend) begin
				if (rreq_wait == 0) begin
					rdata       = dmem[rreq_addr[9:2]];
					rdata_valid = 1'b1;
					rreq_pend   = 1'b0;
				end else
					rreq_wait--;
			end
			d_cmd_ready = ($urandom % 3) != 0;
			inst_ready  = ($urandom % 4) != 0;
		end
	end

	//**********************************************************************
	// Instruction encoding
	//**********************************************************************

	function automatic logic [31:0] enc_r(logic [31:0] f7, logic [31:0] rs2,
			logic [31:0] rs1, logic [31:0] f3, logic [31:0] rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [31:0] imm, logic [31:0] rs1,
			logic [31:0] f3, logic [31:0] rd, logic [31:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] enc_s(logic [31:0] imm, logic [31:0] rs2,
			logic [31:0] rs1, logic [31:0] f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [31:0] imm, logic [31:0] rs2,
			logic [31:0] rs1, logic [31:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] enc_lui(logic [31:0] imm20, logic [31:0] rd);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic logic [31:0] enc_jal(logic [31:0] imm, logic [31:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	//**********************************************************************
	// Program and result helpers
	//**********************************************************************

	task automatic put(logic [31:0] w);
		imem[prog_n] = w;
		prog_n++;
	endtask

	task automatic nops(int n);
		for (int k = 0; k < n; k++)
			put(NOP);
	endtask

	// Two nops after each write keep the next reader safe
	task automatic load_const(logic [31:0] rd, logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;
		put(enc_lui(upper >> 12, rd));
		nops(2);
		put(enc_i(value, rd, 0, rd, 32'h13));
		nops(2);
	endtask

	task automatic new_test();
		logic [31:0] a;
		for (int k = 0; k < 256; k++) begin
			a = k * 4;
			imem[k] = NOP;
			dmem[k] = {~a[15:0], a[15:0]};
		end
		prog_n = RESET_PC >> 2;
		st_addr.delete();
		st_data.delete();
		exp_addr.delete();
		exp_data.delete();
		finished = 1'b0;
	endtask

	task automatic expect_store(logic [31:0] addr, logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic finish_program();
		put(enc_s(32'h100, 0, 0, 2));
		put(enc_jal(0, 0));
		expect_store(32'h100, 32'h0);
	endtask

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic run_program(string name);
		int cycles;
		@(negedge clk);
		rst_n = 1'b0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		for (cycles = 0; cycles < 5000 && !finished; cycles++)
			@(negedge clk);
		if (!finished) begin
			$display("Test %s timed out waiting for the store to the finish address", name);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_stores(string name);
		check({name, " store count"}, exp_addr.size(), st_addr.size());
		for (int k = 0; k < exp_addr.size(); k++) begin
			check({name, " store address"}, exp_addr[k], st_addr[k]);
			check({name, " store data"}, exp_data[k], st_data[k]);
		end
	endtask

	//**********************************************************************
	// Directed tests
	//**********************************************************************

	task automatic test_reset();
		new_test();
		finish_program();
		run_program("reset");
		check("reset first fetch", RESET_PC, first_iaddr);
		check("reset first command", {30'b0, core_pkg::MEM_WRITE}, {30'b0, first_cmd});
		check("reset first address", 32'h100, first_addr);
		check_stores("reset");
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] upper;
		new_test();
		a = $urandom;
		b = $urandom;
		imm = $urandom;
		upper = $urandom;
		load_const(1, a);
		load_const(2, b);
		put(enc_r(0, 2, 1, 0, 3));
		put(enc_r(32'h20, 2, 1, 0, 4));
		put(enc_r(0, 2, 1, 7, 5));
		put(enc_r(0, 2, 1, 6, 6));
		put(enc_r(0, 2, 1, 4, 7));
		put(enc_r(0, 2, 1, 2, 8));
		put(enc_i(imm, 1, 0, 9, 32'h13));
		put(enc_lui(upper, 10));
		nops(2);
		for (int r = 3; r <= 10; r++)
			put(enc_s(32'h200 + (r - 3) * 4, r, 0, 2));
		expect_store(32'h200, a + b);
		expect_store(32'h204, a - b);
		expect_store(32'h208, a & b);
		expect_store(32'h20c, a | b);
		expect_store(32'h210, a ^ b);
		expect_store(32'h214, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		expect_store(32'h218, a + {{20{imm[11]}}, imm[11:0]});
		expect_store(32'h21c, {upper[19:0], 12'b0});
		finish_program();
		run_program("alu");
		check_stores("alu");
	endtask

	task automatic test_load_store();
		logic [31:0] v [3];
		new_test();
		for (int k = 0; k < 3; k++) begin
			v[k] = $urandom;
			dmem[(32'h300 >> 2) + k] = v[k];
		end
		put(enc_i(32'h300, 0, 2, 1, 32'h03));
		put(enc_i(32'h304, 0, 2, 2, 32'h03));
		put(enc_i(32'h308, 0, 2, 3, 32'h03));
		nops(2);
		put(enc_s(32'h200, 1, 0, 2));
		put(enc_s(32'h204, 2, 0, 2));
		put(enc_s(32'h208, 3, 0, 2));
		put(enc_r(0, 3, 1, 0, 4));
		nops(2);
		put(enc_s(32'h20c, 4, 0, 2));
		expect_store(32'h200, v[0]);
		expect_store(32'h204, v[1]);
		expect_store(32'h208, v[2]);
		expect_store(32'h20c, v[0] + v[2]);
		finish_program();
		run_program("load_store");
		check_stores("load_store");
	endtask

	task automatic test_control_flow();
		int jal_idx;
		new_test();
		put(enc_i(5, 0, 0, 1, 32'h13));
		put(enc_i(5, 0, 0, 2, 32'h13));
		nops(2);
		// Taken BEQ skips both stores
		put(enc_b(12, 2, 1, 0));
		put(enc_s(32'h200, 1, 0, 2));
		put(enc_s(32'h204, 1, 0, 2));
		put(enc_i(7, 0, 0, 3, 32'h13));
		put(enc_b(12, 2, 1, 1));
		put(enc_s(32'h208, 2, 0, 2));
		put(enc_s(32'h20c, 2, 0, 2));
		jal_idx = prog_n;
		put(enc_jal(12, 5));
		put(enc_s(32'h210, 1, 0, 2));
		put(enc_s(32'h214, 1, 0, 2));
		nops(2);
		put(enc_s(32'h218, 5, 0, 2));
		put(enc_s(32'h21c, 3, 0, 2));
		expect_store(32'h208, 32'd5);
		expect_store(32'h20c, 32'd5);
		expect_store(32'h218, jal_idx * 4 + 4);
		expect_store(32'h21c, 32'd7);
		finish_program();
		run_program("control_flow");
		check_stores("control_flow");
	endtask

	task automatic test_x0_unknown();
		new_test();
		put(enc_i(123, 0, 0, 0, 32'h13));
		put(enc_i(32'h55, 0, 0, 1, 32'h13));
		nops(2);
		put(enc_s(32'h200, 0, 0, 2));
		// MUL, SLL, a bad opcode and SB must all be ignored
		put(enc_r(1, 1, 1, 0, 1));
		put(enc_r(0, 1, 1, 1, 1));
		put(enc_i(32'h7ff, 1, 0, 1, 32'h7f));
		put(enc_s(32'h208, 1, 0, 0));
		nops(2);
		put(enc_s(32'h204, 1, 0, 2));
		expect_store(32'h200, 32'h0);
		expect_store(32'h204, 32'h55);
		finish_program();
		run_program("x0_unknown");
		check_stores("x0_unknown");
	endtask

	initial begin
		rst_n       = 1'b0;
		inst_ready  = 1'b1;
		inst        = 32'h0;
		inst_valid  = 1'b0;
		d_cmd_ready = 1'b0;
		rdata       = 32'h0;
		rdata_valid = 1'b0;
		finished    = 1'b0;
		ireq_pend   = 1'b0;
		rreq_pend   = 1'b0;
		void'($urandom(53));
		test_reset();
		test_alu();
		test_load_store();
		test_control_flow();
		test_x0_unknown();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/core.sv
test/core_chk.sv
test/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
BUILD     ?= build
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --assert --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
